//--- Bender.yml
package:
  name: serv_lite

sources:
  - target: rtl
    files:
      - src/serv_pkg.sv
      - src/serv_fetch.sv
      - src/serv_state.sv
      - src/serv_decode.sv
      - src/serv_rf.sv
      - src/serv_alu.sv
      - src/serv_dbus_if.sv
      - src/serv_top.sv

  - target: test
    files:
      - tests/serv_properties.sv
      - tests/tb_serv.sv

//--- files.f
src/serv_pkg.sv
src/serv_fetch.sv
src/serv_state.sv
src/serv_decode.sv
src/serv_rf.sv
src/serv_alu.sv
src/serv_dbus_if.sv
src/serv_top.sv
tests/serv_properties.sv
tests/tb_serv.sv

//--- src/serv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module serv_alu import serv_pkg::*; (
   input  logic     clk,
   input  ctrl_t    i_ctrl,
   input  phase_e   i_phase,
   input  bit_cnt_t i_cnt,
   input  logic     i_rs1_bit,
   input  logic     i_rs2_bit,
   input  logic     i_imm_bit,
   output logic     o_rd_bit
);

   logic op_b;
   logic sub;
   logic b_add;
   logic carry;
   logic c_in;
   logic sum;
   logic c_out;

   assign op_b  = i_ctrl.op_b_imm ? i_imm_bit : i_rs2_bit;
   assign sub   = (i_ctrl.alu_op == ALU_SUB);

   // Subtract as rs1 + ~b + 1, the +1 comes in on the first carry
   assign b_add = op_b ^ sub;
   assign c_in  = (i_cnt == '0) ? sub : carry;
   assign sum   = i_rs1_bit ^ b_add ^ c_in;
   assign c_out = (i_rs1_bit & b_add) | (c_in & (i_rs1_bit ^ b_add));

   always_ff @(posedge clk) begin
      if (i_phase == PH_EXEC) begin
         carry <= c_out;
      end
   end

   always_comb begin
      case (i_ctrl.alu_op)
         ALU_ADD,
         ALU_SUB:    o_rd_bit = sum;
         ALU_AND:    o_rd_bit = i_rs1_bit & op_b;
         ALU_OR:     o_rd_bit = i_rs1_bit | op_b;
         ALU_XOR:    o_rd_bit = i_rs1_bit ^ op_b;
         ALU_PASS_B: o_rd_bit = op_b;
         default:    o_rd_bit = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- src/serv_dbus_if.sv
`timescale 1ns/1ps
`default_nettype none

module serv_dbus_if import serv_pkg::*; (
   input  logic      clk,
   input  logic      i_rst_n,
   input  ctrl_t     i_ctrl,
   input  phase_e    i_phase,
   input  logic      i_alu_bit,
   input  logic      i_rs2_bit,
   input  logic      i_dbus_ack,
   output dbus_req_t o_dbus
);

   logic [xlen-1:0] adr_sr;
   logic [xlen-1:0] dat_sr;
   logic            shift_en;
   logic            cyc_q;

   assign shift_en = (i_phase == PH_EXEC) && i_ctrl.is_store;

   // LSB enters first, so the word is aligned after 32 shifts
   always_ff @(posedge clk) begin
      if (shift_en) begin
         adr_sr <= {i_alu_bit, adr_sr[xlen-1:1]};
         dat_sr <= {i_rs2_bit, dat_sr[xlen-1:1]};
      end
   end

   // Armed while the store executes, visible once the phase is STORE
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cyc_q <= 1'b0;
      end else if (o_dbus.cyc && i_dbus_ack) begin
         cyc_q <= 1'b0;
      end else if (shift_en) begin
         cyc_q <= 1'b1;
      end
   end

   assign o_dbus.cyc = cyc_q && (i_phase == PH_STORE);
   assign o_dbus.adr = adr_sr;
   assign o_dbus.dat = dat_sr;

endmodule

`default_nettype wire

//--- src/serv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module serv_decode import serv_pkg::*; (
   input  logic     clk,
   input  instr_u   i_instr,
   input  phase_e   i_phase,
   input  bit_cnt_t i_cnt,
   output ctrl_t    o_ctrl,
   output logic     o_imm_bit
);

   alu_op_e         f3_op;
   logic            f3_ok;
   logic [xlen-1:0] imm;
   logic [xlen-1:0] imm_sr;

   // funct3 is in the same place for OP and OP-IMM
   always_comb begin
      f3_ok = 1'b1;
      case (i_instr.rtype.funct3)
         F3_ADD:  f3_op = ALU_ADD;
         F3_XOR:  f3_op = ALU_XOR;
         F3_OR:   f3_op = ALU_OR;
         F3_AND:  f3_op = ALU_AND;
         default: begin
            f3_op = ALU_ADD;
            f3_ok = 1'b0;
         end
      endcase
   end

   always_comb begin
      o_ctrl        = '0;
      o_ctrl.alu_op = ALU_ADD;
      imm = {{20{i_instr.itype.imm12[11]}}, i_instr.itype.imm12};
      case (i_instr.rtype.opcode)
         OPC_OP: begin
            if (f3_op == ALU_ADD && i_instr.rtype.funct7[5]) begin
               o_ctrl.alu_op = ALU_SUB;
            end else begin
               o_ctrl.alu_op = f3_op;
            end
            o_ctrl.rs1    = i_instr.rtype.rs1;
            o_ctrl.rs2    = i_instr.rtype.rs2;
            o_ctrl.rd     = i_instr.rtype.rd;
            o_ctrl.rd_wen = f3_ok && (i_instr.rtype.rd != '0);
         end
         OPC_OP_IMM: begin
            o_ctrl.alu_op   = f3_op;
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.rs1      = i_instr.itype.rs1;
            o_ctrl.rd       = i_instr.itype.rd;
            o_ctrl.rd_wen   = f3_ok && (i_instr.itype.rd != '0);
         end
         OPC_LUI: begin
            o_ctrl.alu_op   = ALU_PASS_B;
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.rd       = i_instr.utype.rd;
            o_ctrl.rd_wen   = (i_instr.utype.rd != '0);
            imm = {i_instr.utype.imm20, 12'b0};
         end
         OPC_STORE: begin
            // Address is rs1 plus offset, rs2 goes out as data
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.is_store = 1'b1;
            o_ctrl.rs1      = i_instr.stype.rs1;
            o_ctrl.rs2      = i_instr.stype.rs2;
            imm = {{20{i_instr.stype.imm_hi[6]}}, i_instr.stype.imm_hi,
                   i_instr.stype.imm_lo};
         end
         default: ;
      endcase
   end

   // The word lands with the ack, so bit 0 comes straight from the decoder
   always_ff @(posedge clk) begin
      if (i_phase == PH_EXEC && i_cnt == 5'd0) begin
         imm_sr <= {1'b0, imm[xlen-1:1]};
      end else if (i_phase == PH_EXEC) begin
         imm_sr <= {1'b0, imm_sr[xlen-1:1]};
      end
   end

   assign o_imm_bit = (i_cnt == 5'd0) ? imm[0] : imm_sr[0];

endmodule

`default_nettype wire

//--- src/serv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module serv_fetch import serv_pkg::*; #(
   parameter logic [xlen-1:0] RESET_PC = '0
) (
   input  logic            clk,
   input  logic            i_rst_n,
   input  phase_e          i_phase,
   input  logic            i_ibus_ack,
   input  logic [xlen-1:0] i_ibus_rdt,
   output ibus_req_t       o_ibus,
   output instr_u          o_instr
);

   logic [xlen-1:0] pc;
   instr_u          instr_q;
   logic            fetch_ack;

   // Ack only counts while a fetch is outstanding
   assign fetch_ack = (i_phase == PH_FETCH) && i_ibus_ack;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc <= RESET_PC;
      end else if (fetch_ack) begin
         pc <= pc + 32'd4;
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_ack) begin
         instr_q <= i_ibus_rdt;
      end
   end

   assign o_ibus.cyc = (i_phase == PH_FETCH);
   assign o_ibus.adr = pc;
   assign o_instr    = instr_q;

endmodule

`default_nettype wire

//--- src/serv_pkg.sv
`default_nettype none

package serv_pkg;

   localparam int xlen = 32;

   typedef logic [4:0] reg_addr_t;
   typedef logic [4:0] bit_cnt_t;

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;

   // Instruction word views, MSB first
   typedef struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm12;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_t;

   typedef struct packed {
      logic [19:0] imm20;
      reg_addr_t   rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   typedef union packed {
      r_fmt_t rtype;
      i_fmt_t itype;
      s_fmt_t stype;
      u_fmt_t utype;
   } instr_u;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_e;

   typedef struct packed {
      alu_op_e   alu_op;
      logic      op_b_imm;
      logic      rd_wen;
      logic      is_store;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
   } ctrl_t;

   typedef struct packed {
      logic            cyc;
      logic [xlen-1:0] adr;
   } ibus_req_t;

   typedef struct packed {
      logic            cyc;
      logic [xlen-1:0] adr;
      logic [xlen-1:0] dat;
   } dbus_req_t;

   typedef enum logic [1:0] {
      PH_FETCH,
      PH_EXEC,
      PH_STORE
   } phase_e;

endpackage

`default_nettype wire

//--- src/serv_rf.sv
`timescale 1ns/1ps
`default_nettype none

module serv_rf import serv_pkg::*; (
   input  logic     clk,
   input  ctrl_t    i_ctrl,
   input  phase_e   i_phase,
   input  bit_cnt_t i_cnt,
   input  logic     i_rd_bit,
   output logic     o_rs1_bit,
   output logic     o_rs2_bit
);

   logic [xlen-1:0] regs [32];
   logic            wr_en;

   assign wr_en = (i_phase == PH_EXEC) && i_ctrl.rd_wen;

   // Old bit is read before the edge writes the new one
   always_ff @(posedge clk) begin
      if (wr_en) begin
         regs[i_ctrl.rd][i_cnt] <= i_rd_bit;
      end
   end

   // x0 is never written and reads as zero
   assign o_rs1_bit = (i_ctrl.rs1 != '0) && regs[i_ctrl.rs1][i_cnt];
   assign o_rs2_bit = (i_ctrl.rs2 != '0) && regs[i_ctrl.rs2][i_cnt];

endmodule

`default_nettype wire

//--- src/serv_state.sv
`timescale 1ns/1ps
`default_nettype none

module serv_state import serv_pkg::*; (
   input  logic     clk,
   input  logic     i_rst_n,
   input  logic     i_ibus_ack,
   input  logic     i_dbus_ack,
   input  logic     i_is_store,
   output phase_e   o_phase,
   output bit_cnt_t o_cnt,
   output logic     o_cnt_done
);

   phase_e   phase;
   bit_cnt_t cnt;
   logic     cnt_done;

   assign cnt_done = (phase == PH_EXEC) && (cnt == 5'd31);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         phase <= PH_FETCH;
         cnt   <= '0;
      end else begin
         case (phase)
            PH_FETCH: begin
               if (i_ibus_ack) begin
                  phase <= PH_EXEC;
               end
            end
            PH_EXEC: begin
               // Wraps back to zero after bit 31
               cnt <= cnt + 5'd1;
               if (cnt_done) begin
                  phase <= i_is_store ? PH_STORE : PH_FETCH;
               end
            end
            PH_STORE: begin
               if (i_dbus_ack) begin
                  phase <= PH_FETCH;
               end
            end
            default: phase <= PH_FETCH;
         endcase
      end
   end

   assign o_phase    = phase;
   assign o_cnt      = cnt;
   assign o_cnt_done = cnt_done;

endmodule

`default_nettype wire

//--- src/serv_top.sv
`timescale 1ns/1ps
`default_nettype none

module serv_top import serv_pkg::*; #(
   parameter logic [xlen-1:0] RESET_PC = '0
) (
   input  logic            clk,
   input  logic            i_rst_n,
   output ibus_req_t       o_ibus,
   input  logic            i_ibus_ack,
   input  logic [xlen-1:0] i_ibus_rdt,
   output dbus_req_t       o_dbus,
   input  logic            i_dbus_ack
);

   phase_e   phase;
   bit_cnt_t cnt;
   instr_u   instr;
   ctrl_t    ctrl;
   logic     imm_bit;
   logic     rs1_bit;
   logic     rs2_bit;
   logic     rd_bit;

   serv_fetch #(
      .RESET_PC (RESET_PC)
   ) fetch (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_phase    (phase),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_ibus     (o_ibus),
      .o_instr    (instr)
   );

   serv_state state (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_is_store (ctrl.is_store),
      .o_phase    (phase),
      .o_cnt      (cnt),
      .o_cnt_done ()
   );

   serv_decode decode (
      .clk       (clk),
      .i_instr   (instr),
      .i_phase   (phase),
      .i_cnt     (cnt),
      .o_ctrl    (ctrl),
      .o_imm_bit (imm_bit)
   );

   serv_rf rf (
      .clk       (clk),
      .i_ctrl    (ctrl),
      .i_phase   (phase),
      .i_cnt     (cnt),
      .i_rd_bit  (rd_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   serv_alu alu (
      .clk       (clk),
      .i_ctrl    (ctrl),
      .i_phase   (phase),
      .i_cnt     (cnt),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .i_imm_bit (imm_bit),
      .o_rd_bit  (rd_bit)
   );

   serv_dbus_if dbus_if (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ctrl     (ctrl),
      .i_phase    (phase),
      .i_alu_bit  (rd_bit),
      .i_rs2_bit  (rs2_bit),
      .i_dbus_ack (i_dbus_ack),
      .o_dbus     (o_dbus)
   );

endmodule

`default_nettype wire

//--- tests/serv_properties.sv
`timescale 1ns/1ps
`default_nettype none

module serv_properties import serv_pkg::*; (
   input logic      clk,
   input logic      i_rst_n,
   input ibus_req_t i_ibus,
   input logic      i_ibus_ack,
   input dbus_req_t i_dbus,
   input logic      i_dbus_ack
);

   // Only one bus owns the core at a time
   one_bus_active: assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_ibus.cyc && i_dbus.cyc))
      else $error("instruction and data requests are active together");

   ibus_held: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus.cyc && !i_ibus_ack |=> i_ibus.cyc && $stable(i_ibus.adr))
      else $error("instruction request changed before its ack");

   dbus_held: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_dbus.cyc && !i_dbus_ack |=>
         i_dbus.cyc && $stable(i_dbus.adr) && $stable(i_dbus.dat))
      else $error("store request changed before its ack");

   ibus_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ibus.cyc |-> i_ibus.adr[1:0] == 2'b00)
      else $error("fetch address is not word aligned");

endmodule

bind serv_top serv_properties props (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .i_ibus     (o_ibus),
   .i_ibus_ack (i_ibus_ack),
   .i_dbus     (o_dbus),
   .i_dbus_ack (i_dbus_ack)
);

`default_nettype wire

//--- tests/tb_serv.sv
`timescale 1ns/1ps
`default_nettype none

module tb_serv import serv_pkg::*; ();

   localparam logic [31:0] RESET_PC    = 32'h0000_1000;
   localparam int          CLK_PERIOD  = 20;
   localparam int          NUM_INSTR   = 600;
   localparam int          MAX_DELAY   = 7;
   localparam int          WATCHDOG_NS = NUM_INSTR * (33 + 2 * (MAX_DELAY + 1) + 2) * CLK_PERIOD
                                         + 5 * CLK_PERIOD;

   logic        clk;
   logic        rst_n;
   logic        ibus_ack;
   logic [31:0] ibus_rdt;
   logic        dbus_ack;
   ibus_req_t   ibus;
   dbus_req_t   dbus;

   logic [31:0] lfsr;
   logic [31:0] model_rf [32];
   logic [31:0] exp_adr_q [$];
   logic [31:0] exp_dat_q [$];
   int          fetch_count;

   serv_top #(
      .RESET_PC (RESET_PC)
   ) dut (
      .clk        (clk),
      .i_rst_n    (rst_n),
      .o_ibus     (ibus),
      .i_ibus_ack (ibus_ack),
      .i_ibus_rdt (ibus_rdt),
      .o_dbus     (dbus),
      .i_dbus_ack (dbus_ack)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // Galois LFSR, one step per bit drawn
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [2:0] pick_f3();
      case (2'(rand_bits(2)))
         2'd0:    return F3_ADD;
         2'd1:    return F3_XOR;
         2'd2:    return F3_OR;
         default: return F3_AND;
      endcase
   endfunction

   function automatic logic [31:0] make_instr(input int n);
      logic [2:0]  kind;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [11:0] imm;
      logic [19:0] upper;
      upper = 20'(rand_bits(20));
      // x1 to x31 get known values before anything reads them
      if (n < 31) begin
         return {upper, 5'(n + 1), OPC_LUI};
      end
      kind = 3'(rand_bits(3));
      rd   = 5'(rand_bits(5));
      rs1  = 5'(rand_bits(5));
      rs2  = 5'(rand_bits(5));
      f3   = pick_f3();
      f7   = (rand_bits(1) == 1 && f3 == F3_ADD) ? 7'b0100000 : 7'b0000000;
      imm  = 12'(rand_bits(12));
      case (kind)
         3'd0:             return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
         3'd1, 3'd2, 3'd3: return {f7, rs2, rs1, f3, rd, OPC_OP};
         3'd7:             return {upper, rd, OPC_LUI};
         default:          return {imm, rs1, f3, rd, OPC_OP_IMM};
      endcase
   endfunction

   // rd value of the instruction, or the store address for SW
   function automatic logic [31:0] ref_result(input logic [31:0] instr);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm_i;
      logic [31:0] imm_s;
      a     = model_rf[instr[19:15]];
      imm_i = {{20{instr[31]}}, instr[31:20]};
      imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      b     = (instr[6:0] == OPC_OP) ? model_rf[instr[24:20]] : imm_i;
      case (instr[6:0])
         OPC_LUI:   return {instr[31:12], 12'h000};
         OPC_STORE: return a + imm_s;
         default: begin
            case (instr[14:12])
               F3_XOR:  return a ^ b;
               F3_OR:   return a | b;
               F3_AND:  return a & b;
               default: return (instr[6:0] == OPC_OP && instr[30]) ? a - b : a + b;
            endcase
         end
      endcase
   endfunction

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         $display("error at %0t ns: %s is %08h, expected %08h", $time, name, got, expected);
         abort_run();
      end
   endtask

   initial begin : drive
      logic [31:0] instr;
      logic [31:0] result;
      int          delay;
      rst_n       = 1'b0;
      ibus_ack    = 1'b0;
      ibus_rdt    = '0;
      dbus_ack    = 1'b0;
      lfsr        = 32'h2760e93d;
      model_rf[0] = '0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      for (int n = 0; n < NUM_INSTR; n++) begin
         do @(posedge clk); while (!ibus.cyc);
         delay = rand_bits(3);
         repeat (delay) @(posedge clk);
         instr  = make_instr(n);
         result = ref_result(instr);
         if (instr[6:0] == OPC_STORE) begin
            exp_adr_q.push_back(result);
            exp_dat_q.push_back(model_rf[instr[24:20]]);
         end else if (instr[11:7] != 5'd0) begin
            model_rf[instr[11:7]] = result;
         end
         ibus_rdt <= instr;
         ibus_ack <= 1'b1;
         @(posedge clk);
         ibus_ack <= 1'b0;
         if (instr[6:0] == OPC_STORE) begin
            do @(posedge clk); while (!dbus.cyc);
            delay = rand_bits(3);
            repeat (delay) @(posedge clk);
            dbus_ack <= 1'b1;
            @(posedge clk);
            dbus_ack <= 1'b0;
         end
      end
      // The next fetch shows that the last instruction retired
      do @(posedge clk); while (!ibus.cyc);
      check_value("o_ibus.adr", ibus.adr, RESET_PC + 32'(4 * NUM_INSTR));
      if (exp_adr_q.size() == 0 && fetch_count == NUM_INSTR) begin
         $display("TEST OK");
         $finish;
      end else begin
         $display("%0d fetches acknowledged and %0d stores never reached the data bus",
                  fetch_count, exp_adr_q.size());
         abort_run();
      end
   end

   initial begin : compare
      fetch_count = 0;
      forever begin
         @(posedge clk);
         if (rst_n && ibus.cyc && ibus_ack) begin
            check_value("o_ibus.adr", ibus.adr, RESET_PC + 32'(4 * fetch_count));
            fetch_count++;
         end
         if (rst_n && dbus.cyc && dbus_ack) begin
            if (exp_adr_q.size() == 0) begin
               $display("a store reached the data bus that the program never issued");
               abort_run();
            end else begin
               check_value("o_dbus.adr", dbus.adr, exp_adr_q.pop_front());
               check_value("o_dbus.dat", dbus.dat, exp_dat_q.pop_front());
            end
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("timeout: the core did not finish all instructions in time");
      abort_run();
   end

endmodule

`default_nettype wire
